// ==== Makefile ====
# Verilator build and run of the hit/miss stage testbench

TOP := hit_miss_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/hit_miss_tb.sv ====
`timescale 1ns/1ns
`include "hit_miss_cfg.svh"

module hit_miss_tb
  import hit_miss_pkg::*;
;

  localparam int clk_period = 100;
  localparam int n_directed = 9;
  localparam int n_random   = 24;
  localparam int n_entries  = n_directed + n_random;
  // budget per entry, watchdog fires after this
  localparam int max_cycles = n_entries * 20;

  // one table row, expected values only used on directed rows
  typedef struct {
    string                 name;
    id_t                   id;
    logic [`HM_ADDR_W-1:0] addr;
    logic                  write;
    logic                  unlock;
    logic [3:0]            cnt_down;
    logic                  auto_cd;
    int                    hold;
    logic                  from_model;
    logic                  exp_miss;
    logic                  exp_refill;
    logic                  exp_evict;
    tag_t                  exp_evict_tag;
  } entry_t;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  valid_i;
  logic                  ready_o;
  id_t                   id_i;
  logic [`HM_ADDR_W-1:0] addr_i;
  logic                  write_i;
  logic                  hit_valid_o;
  logic                  hit_ready_i;
  logic                  miss_valid_o;
  logic                  miss_ready_i;
  id_t                   out_id_o;
  logic [`HM_ADDR_W-1:0] out_addr_o;
  way_t                  out_way_o;
  logic                  out_refill_o;
  logic                  out_evict_o;
  tag_t                  out_evict_tag_o;
  logic                  unlock_valid_i;
  index_t                unlock_index_i;
  logic                  cnt_down_valid_i;
  id_t                   cnt_down_id_i;

  entry_t      tbl[$];
  logic [31:0] lfsr_q;
  int          error_count;
  int          pass_count;
  int          fail_count;

  // reference model state
  tag_t m_tag   [`HM_SETS][`HM_WAYS];
  logic m_valid [`HM_SETS][`HM_WAYS];
  logic m_dirty [`HM_SETS][`HM_WAYS];
  int   m_rr    [`HM_SETS];
  int   m_cnt   [4];
  logic m_lock  [`HM_SETS];

  hit_miss_top uut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (valid_i),
    .ready_o          (ready_o),
    .id_i             (id_i),
    .addr_i           (addr_i),
    .write_i          (write_i),
    .hit_valid_o      (hit_valid_o),
    .hit_ready_i      (hit_ready_i),
    .miss_valid_o     (miss_valid_o),
    .miss_ready_i     (miss_ready_i),
    .out_id_o         (out_id_o),
    .out_addr_o       (out_addr_o),
    .out_way_o        (out_way_o),
    .out_refill_o     (out_refill_o),
    .out_evict_o      (out_evict_o),
    .out_evict_tag_o  (out_evict_tag_o),
    .unlock_valid_i   (unlock_valid_i),
    .unlock_index_i   (unlock_index_i),
    .cnt_down_valid_i (cnt_down_valid_i),
    .cnt_down_id_i    (cnt_down_id_i)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // random bits and address helpers
  ////////////////////////////////////////////////////////////////////////////
  // galois lfsr, one step per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 32'ha300_0000;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // tag on top, then set index, then offset
  function automatic logic [`HM_ADDR_W-1:0] make_addr(input tag_t t, input index_t s,
                                                       input logic [`HM_OFFSET_W-1:0] off);
    return {t, s, off};
  endfunction

  task automatic add_entry(input string name, input id_t id,
                           input logic [`HM_ADDR_W-1:0] addr, input logic wr,
                           input logic unlock, input logic [3:0] cd, input int hold,
                           input logic exp_miss, input logic exp_refill,
                           input logic exp_evict, input tag_t exp_tag);
    entry_t e;
    e.name          = name;
    e.id            = id;
    e.addr          = addr;
    e.write         = wr;
    e.unlock        = unlock;
    e.cnt_down      = cd;
    e.auto_cd       = 1'b0;
    e.hold          = hold;
    e.from_model    = 1'b0;
    e.exp_miss      = exp_miss;
    e.exp_refill    = exp_refill;
    e.exp_evict     = exp_evict;
    e.exp_evict_tag = exp_tag;
    tbl.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model of lookup and routing
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_lookup(input id_t id, input logic [`HM_ADDR_W-1:0] addr,
                              input logic wr, output logic to_miss, output way_t way,
                              output logic refill, output logic evict,
                              output tag_t evict_tag);
    index_t s;
    tag_t   t;
    int     hit_w;
    int     vic;
    s     = addr[`HM_OFFSET_W +: `HM_INDEX_W];
    t     = addr[(`HM_OFFSET_W + `HM_INDEX_W) +: `HM_TAG_W];
    hit_w = -1;
    for (int w = 0; w < `HM_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        hit_w = w;
      end
    end
    if (hit_w >= 0) begin
      way       = way_t'(2'b01 << hit_w);
      refill    = 1'b0;
      evict     = 1'b0;
      evict_tag = '0;
      // busy id sends the hit out behind its misses
      to_miss   = (m_cnt[id] != 0);
      if (wr) begin
        m_dirty[s][hit_w] = 1'b1;
      end
    end else begin
      vic = -1;
      for (int w = 0; w < `HM_WAYS; w++) begin
        if (!m_valid[s][w] && vic < 0) begin
          vic = w;
        end
      end
      // full set, round-robin pick and toggle
      if (vic < 0) begin
        vic     = m_rr[s];
        m_rr[s] = 1 - m_rr[s];
      end
      way            = way_t'(2'b01 << vic);
      refill         = 1'b1;
      to_miss        = 1'b1;
      evict          = m_valid[s][vic] && m_dirty[s][vic];
      evict_tag      = evict ? m_tag[s][vic] : '0;
      m_tag[s][vic]   = t;
      m_valid[s][vic] = 1'b1;
      m_dirty[s][vic] = wr;
    end
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test, field, exp, act);
    error_count++;
  endtask

  task automatic pulse_unlock(input index_t s);
    unlock_valid_i = 1'b1;
    unlock_index_i = s;
    @(negedge clk_i);
    unlock_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table entry, start to finish
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_entry(input entry_t e);
    int         errs_before;
    int         n;
    index_t     s;
    logic [3:0] cd;
    logic       m_miss;
    logic       m_refill;
    logic       m_evict;
    tag_t       m_etag;
    logic       exp_miss;
    logic       exp_refill;
    logic       exp_evict;
    tag_t       exp_tag;
    way_t       exp_way;
    logic [`HM_ID_W+`HM_ADDR_W+`HM_WAYS+2+`HM_TAG_W-1:0] snap;
    errs_before = error_count;
    s  = e.addr[`HM_OFFSET_W +: `HM_INDEX_W];
    cd = e.cnt_down;
    // random rows count down now and then, always before a counter gets high
    if (e.auto_cd) begin
      for (int i = 0; i < 4; i++) begin
        cd[i] = (m_cnt[i] > 0) && ((m_cnt[i] >= 4) || lfsr_step());
      end
    end
    for (int i = 0; i < 4; i++) begin
      if (cd[i]) begin
        cnt_down_valid_i = 1'b1;
        cnt_down_id_i    = id_t'(i);
        @(negedge clk_i);
        cnt_down_valid_i = 1'b0;
        m_cnt[i]--;
      end
    end
    // offer the descriptor, it goes in on the next rising edge with ready_o
    valid_i = 1'b1;
    id_i    = e.id;
    addr_i  = e.addr;
    write_i = e.write;
    n = 0;
    while (!ready_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!ready_o) begin
      $display("[ERROR] %s: the stage never became ready for the descriptor", e.name);
      error_count++;
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    model_lookup(e.id, e.addr, e.write, m_miss, exp_way, m_refill, m_evict, m_etag);
    exp_miss   = e.from_model ? m_miss : e.exp_miss;
    exp_refill = e.from_model ? m_refill : e.exp_refill;
    exp_evict  = e.from_model ? m_evict : e.exp_evict;
    exp_tag    = e.from_model ? m_etag : e.exp_evict_tag;
    // locked set, nothing may come out until the unlock
    if (m_lock[s]) begin
      repeat (4) begin
        @(negedge clk_i);
        if (hit_valid_o || miss_valid_o) begin
          $display("[ERROR] %s: output raised while its set was locked", e.name);
          error_count++;
        end
      end
      pulse_unlock(s);
      m_lock[s] = 1'b0;
    end
    n = 0;
    while (!(hit_valid_o || miss_valid_o) && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!(hit_valid_o || miss_valid_o)) begin
      $display("[ERROR] %s: no output appeared on either port", e.name);
      error_count++;
    end else begin
      if (miss_valid_o !== exp_miss)
        report_mismatch(e.name, "miss_valid_o", exp_miss, miss_valid_o);
      if (hit_valid_o !== !exp_miss)
        report_mismatch(e.name, "hit_valid_o", !exp_miss, hit_valid_o);
      if (out_id_o !== e.id)
        report_mismatch(e.name, "out_id_o", e.id, out_id_o);
      if (out_addr_o !== e.addr)
        report_mismatch(e.name, "out_addr_o", e.addr, out_addr_o);
      if (out_way_o !== exp_way)
        report_mismatch(e.name, "out_way_o", exp_way, out_way_o);
      if (out_refill_o !== exp_refill)
        report_mismatch(e.name, "out_refill_o", exp_refill, out_refill_o);
      if (out_evict_o !== exp_evict)
        report_mismatch(e.name, "out_evict_o", exp_evict, out_evict_o);
      if (out_evict_tag_o !== exp_tag)
        report_mismatch(e.name, "out_evict_tag_o", exp_tag, out_evict_tag_o);
      snap = {out_id_o, out_addr_o, out_way_o, out_refill_o, out_evict_o, out_evict_tag_o};
      // back-pressure, output and fields must sit still
      for (int k = 0; k < e.hold; k++) begin
        @(negedge clk_i);
        if (!(hit_valid_o || miss_valid_o)) begin
          $display("[ERROR] %s: output valid dropped under back-pressure", e.name);
          error_count++;
        end
        if (ready_o) begin
          $display("[ERROR] %s: ready_o went high with a descriptor held", e.name);
          error_count++;
        end
        if ({out_id_o, out_addr_o, out_way_o, out_refill_o, out_evict_o,
             out_evict_tag_o} !== snap) begin
          $display("[ERROR] %s: output fields changed under back-pressure", e.name);
          error_count++;
        end
      end
      hit_ready_i  = 1'b1;
      miss_ready_i = 1'b1;
      @(negedge clk_i);
      hit_ready_i  = 1'b0;
      miss_ready_i = 1'b0;
      if (hit_valid_o || miss_valid_o || !ready_o) begin
        $display("[ERROR] %s: the stage did not empty after the handoff", e.name);
        error_count++;
      end
      // handoff locks the set, a miss-port handoff counts up its id
      m_lock[s] = 1'b1;
      if (m_miss) begin
        m_cnt[e.id]++;
      end
      if (e.unlock) begin
        pulse_unlock(s);
        m_lock[s] = 1'b0;
      end
    end
    if (error_count == errs_before) begin
      pass_count++;
      $display("PASS  %s", e.name);
    end else begin
      fail_count++;
      $display("FAIL  %s", e.name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table and main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    entry_t e;
    logic [31:0] r;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    valid_i          = 1'b0;
    id_i             = '0;
    addr_i           = '0;
    write_i          = 1'b0;
    hit_ready_i      = 1'b0;
    miss_ready_i     = 1'b0;
    unlock_valid_i   = 1'b0;
    unlock_index_i   = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i    = '0;
    lfsr_q           = 32'hd1e6;
    error_count      = 0;
    pass_count       = 0;
    fail_count       = 0;
    for (int s = 0; s < `HM_SETS; s++) begin
      m_rr[s]   = 0;
      m_lock[s] = 1'b0;
      for (int w = 0; w < `HM_WAYS; w++) begin
        m_tag[s][w]   = '0;
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    for (int i = 0; i < 4; i++) begin
      m_cnt[i] = 0;
    end

    // cold read misses, repeat after count-down hits
    add_entry("cold_read", 2'd0, make_addr(9'h011, 3'd1, 4'h0), 1'b0, 1'b1, 4'b0000, 0,
              1'b1, 1'b1, 1'b0, 9'h000);
    add_entry("repeat_hit", 2'd0, make_addr(9'h011, 3'd1, 4'h0), 1'b0, 1'b1, 4'b0001, 0,
              1'b0, 1'b0, 1'b0, 9'h000);
    // fill set 2 with writes, third one throws out the dirty first line
    add_entry("fill_way0", 2'd1, make_addr(9'h021, 3'd2, 4'h0), 1'b1, 1'b1, 4'b0000, 0,
              1'b1, 1'b1, 1'b0, 9'h000);
    add_entry("fill_way1", 2'd1, make_addr(9'h022, 3'd2, 4'h4), 1'b1, 1'b1, 4'b0000, 0,
              1'b1, 1'b1, 1'b0, 9'h000);
    add_entry("evict_first", 2'd1, make_addr(9'h023, 3'd2, 4'h8), 1'b1, 1'b1, 4'b0000, 0,
              1'b1, 1'b1, 1'b1, 9'h021);
    // id 1 still has misses out
    add_entry("busy_hit", 2'd1, make_addr(9'h022, 3'd2, 4'h0), 1'b0, 1'b1, 4'b0000, 0,
              1'b1, 1'b0, 1'b0, 9'h000);
    // set 3 left locked, next descriptor there has to wait
    add_entry("lock_hold", 2'd2, make_addr(9'h031, 3'd3, 4'h0), 1'b0, 1'b0, 4'b0000, 0,
              1'b1, 1'b1, 1'b0, 9'h000);
    add_entry("stall_unlock", 2'd3, make_addr(9'h032, 3'd3, 4'h0), 1'b0, 1'b1, 4'b0000, 0,
              1'b1, 1'b1, 1'b0, 9'h000);
    add_entry("backpressure", 2'd0, make_addr(9'h011, 3'd1, 4'hc), 1'b0, 1'b1, 4'b0000, 5,
              1'b0, 1'b0, 1'b0, 9'h000);

    // random rows, few tags in four sets so hits and evictions both happen
    for (int i = 0; i < n_random; i++) begin
      e.name  = $sformatf("random_%0d", i);
      r       = rand_bits(2);
      e.id    = r[1:0];
      r       = rand_bits(8);
      e.addr  = make_addr({7'h02, r[7:6]}, {1'b0, r[5:4]}, r[3:0]);
      r       = rand_bits(2);
      e.write = r[0];
      e.hold  = r[1] ? 2 : 0;
      e.unlock        = 1'b1;
      e.cnt_down      = 4'b0000;
      e.auto_cd       = 1'b1;
      e.from_model    = 1'b1;
      e.exp_miss      = 1'b0;
      e.exp_refill    = 1'b0;
      e.exp_evict     = 1'b0;
      e.exp_evict_tag = '0;
      tbl.push_back(e);
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // idle state straight after reset
    if (!ready_o || hit_valid_o || miss_valid_o) begin
      $display("[ERROR] reset: ready_o low or an output valid high after reset");
      error_count++;
    end

    foreach (tbl[i]) begin
      run_entry(tbl[i]);
    end

    $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
             pass_count + fail_count, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog, sized from the number of table entries
  initial begin
    #((max_cycles + 10) * clk_period);
    $display("timeout: the run did not finish within %0d cycles", max_cycles + 10);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== logic/hit_miss_cfg.svh ====
`ifndef HIT_MISS_CFG_SVH
`define HIT_MISS_CFG_SVH

// cache geometry
`define HM_SETS      8
`define HM_WAYS      2

// address split, offset at the bottom, then index, then tag
`define HM_INDEX_W   3
`define HM_OFFSET_W  4
`define HM_TAG_W     9
`define HM_ADDR_W    (`HM_OFFSET_W + `HM_INDEX_W + `HM_TAG_W)

// descriptor id width
`define HM_ID_W      2

// outstanding miss counter per id, up to 7 misses in flight
`define HM_CNT_W     3

`endif

// ==== logic/hit_miss_pkg.sv ====
`include "hit_miss_cfg.svh"

package hit_miss_pkg;

  typedef logic [`HM_INDEX_W-1:0] index_t;
  typedef logic [`HM_TAG_W-1:0]   tag_t;
  // one bit per way, one-hot when it names a line
  typedef logic [`HM_WAYS-1:0]    way_t;
  typedef logic [`HM_ID_W-1:0]    id_t;

  // incoming descriptor
  typedef struct packed {
    id_t                   id;
    logic [`HM_ADDR_W-1:0] addr;
    // 1 for a write, 0 for a read
    logic                  write;
  } desc_t;

  // outcome of the tag store lookup
  typedef struct packed {
    logic hit;
    way_t way;
    // victim line was valid and dirty
    logic evict;
    tag_t evict_tag;
  } lookup_res_t;

  // outcome of the miss counter check
  typedef struct packed {
    logic id_busy;
  } guard_res_t;

  // set index field of an address
  function automatic index_t addr_index(input logic [`HM_ADDR_W-1:0] addr);
    return addr[`HM_OFFSET_W +: `HM_INDEX_W];
  endfunction

  // tag field of an address
  function automatic tag_t addr_tag(input logic [`HM_ADDR_W-1:0] addr);
    return addr[(`HM_OFFSET_W + `HM_INDEX_W) +: `HM_TAG_W];
  endfunction

endpackage

// ==== logic/hit_miss_top.sv ====
`timescale 1ns/1ns
`include "hit_miss_cfg.svh"

module hit_miss_top
  import hit_miss_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // descriptor in
  input  logic                  valid_i,
  output logic                  ready_o,
  input  id_t                   id_i,
  input  logic [`HM_ADDR_W-1:0] addr_i,
  input  logic                  write_i,
  // hit port and miss port
  output logic                  hit_valid_o,
  input  logic                  hit_ready_i,
  output logic                  miss_valid_o,
  input  logic                  miss_ready_i,
  // fields shared by both ports
  output id_t                   out_id_o,
  output logic [`HM_ADDR_W-1:0] out_addr_o,
  output way_t                  out_way_o,
  output logic                  out_refill_o,
  output logic                  out_evict_o,
  output tag_t                  out_evict_tag_o,
  // pulses from downstream
  input  logic                  unlock_valid_i,
  input  index_t                unlock_index_i,
  input  logic                  cnt_down_valid_i,
  input  id_t                   cnt_down_id_i
);

  desc_t  in_desc;
  desc_t  out_desc;
  index_t held_index;
  logic   set_locked;
  logic   lock_set;
  logic   miss_up;

  stage_if #(.payload_t(desc_t))       desc_bus ();
  stage_if #(.payload_t(lookup_res_t)) look_bus ();
  stage_if #(.payload_t(guard_res_t))  guard_bus ();

  // pack and unpack the plain ports
  assign in_desc.id    = id_i;
  assign in_desc.addr  = addr_i;
  assign in_desc.write = write_i;
  assign out_id_o      = out_desc.id;
  assign out_addr_o    = out_desc.addr;

  route_ctrl u_route_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .desc_i          (in_desc),
    .hit_valid_o     (hit_valid_o),
    .hit_ready_i     (hit_ready_i),
    .miss_valid_o    (miss_valid_o),
    .miss_ready_i    (miss_ready_i),
    .out_desc_o      (out_desc),
    .out_way_o       (out_way_o),
    .out_refill_o    (out_refill_o),
    .out_evict_o     (out_evict_o),
    .out_evict_tag_o (out_evict_tag_o),
    .desc_bus        (desc_bus),
    .look_bus        (look_bus),
    .guard_bus       (guard_bus),
    .held_index_o    (held_index),
    .set_locked_i    (set_locked),
    .lock_set_o      (lock_set),
    .miss_up_o       (miss_up)
  );

  tag_lookup u_tag_lookup (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .desc_bus (desc_bus),
    .look_bus (look_bus)
  );

  line_guard u_line_guard (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .desc_bus         (desc_bus),
    .guard_bus        (guard_bus),
    .held_index_i     (held_index),
    .set_locked_o     (set_locked),
    .lock_set_i       (lock_set),
    .miss_up_i        (miss_up),
    .unlock_valid_i   (unlock_valid_i),
    .unlock_index_i   (unlock_index_i),
    .cnt_down_valid_i (cnt_down_valid_i),
    .cnt_down_id_i    (cnt_down_id_i)
  );

endmodule

// ==== logic/line_guard.sv ====
`timescale 1ns/1ns
`include "hit_miss_cfg.svh"

module line_guard
  import hit_miss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  stage_if.consumer desc_bus,
  stage_if.producer guard_bus,
  input  index_t    held_index_i,
  output logic      set_locked_o,
  input  logic      lock_set_i,
  input  logic      miss_up_i,
  input  logic      unlock_valid_i,
  input  index_t    unlock_index_i,
  input  logic      cnt_down_valid_i,
  input  id_t       cnt_down_id_i
);

  localparam int unsigned n_ids = 2 ** `HM_ID_W;

  // one lock bit per set
  logic [`HM_SETS-1:0]              lock_q;
  logic [`HM_SETS-1:0]              lock_d;
  // outstanding misses per id
  logic [n_ids-1:0][`HM_CNT_W-1:0] cnt_q;
  logic [n_ids-1:0][`HM_CNT_W-1:0] cnt_d;

  // copy of the descriptor taken off the bus
  id_t        id_q;
  index_t     idx_q;
  guard_res_t res_q;
  logic       res_valid_q;
  logic       take;

  // tag_lookup paces the descriptor bus, this copy follows the same transfer
  assign take = desc_bus.valid && desc_bus.ready;

  ////////////////////////////////////////////////////////////////////////////
  // set lock table
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    lock_d = lock_q;
    if (unlock_valid_i) begin
      lock_d[unlock_index_i] = 1'b0;
    end
    // set comes last so a same-cycle lock and unlock leave it locked
    if (lock_set_i) begin
      lock_d[idx_q] = 1'b1;
    end
  end

  // looked up every cycle, unlocks can land at any time
  assign set_locked_o = lock_q[held_index_i];

  ////////////////////////////////////////////////////////////////////////////
  // miss counters
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    cnt_d = cnt_q;
    if (miss_up_i) begin
      cnt_d[id_q] = cnt_d[id_q] + 1'b1;
    end
    // up and down on one id cancel out
    if (cnt_down_valid_i) begin
      cnt_d[cnt_down_id_i] = cnt_d[cnt_down_id_i] - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= '0;
      cnt_q  <= '0;
    end else begin
      lock_q <= lock_d;
      cnt_q  <= cnt_d;
    end
  end

  // result slot, released on the same handoff as the lookup result
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (guard_bus.valid && guard_bus.ready) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      id_q          <= desc_bus.payload.id;
      idx_q         <= addr_index(desc_bus.payload.addr);
      res_q.id_busy <= (cnt_q[desc_bus.payload.id] != '0);
    end
  end

  assign guard_bus.valid   = res_valid_q;
  assign guard_bus.payload = res_q;

  // downstream never has more misses in flight than the counter holds
  cnt_no_overflow_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (miss_up_i && !(cnt_down_valid_i && (cnt_down_id_i == id_q))) |-> (cnt_q[id_q] != '1))
    else $error("line_guard: miss counter overflow");

  // count-down only for a miss that was counted up before
  cnt_no_underflow_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_down_valid_i |-> (cnt_q[cnt_down_id_i] != '0))
    else $error("line_guard: count-down at zero");

endmodule

// ==== logic/route_ctrl.sv ====
`timescale 1ns/1ns

module route_ctrl
  import hit_miss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // descriptor in
  input  logic      valid_i,
  output logic      ready_o,
  input  desc_t     desc_i,
  // hit and miss ports
  output logic      hit_valid_o,
  input  logic      hit_ready_i,
  output logic      miss_valid_o,
  input  logic      miss_ready_i,
  output desc_t     out_desc_o,
  output way_t      out_way_o,
  output logic      out_refill_o,
  output logic      out_evict_o,
  output tag_t      out_evict_tag_o,
  // lookup side
  stage_if.producer desc_bus,
  stage_if.consumer look_bus,
  stage_if.consumer guard_bus,
  output index_t    held_index_o,
  input  logic      set_locked_i,
  output logic      lock_set_o,
  output logic      miss_up_o
);

  desc_t desc_q;
  // a descriptor sits in the stage
  logic  held_q;
  // its lookup request has gone out
  logic  issued_q;
  logic  accept;
  logic  results_ok;
  logic  to_hit;
  logic  handoff;

  // ready_o ignores valid_i and drops while a descriptor is held
  assign ready_o = ~held_q;
  assign accept  = valid_i && ready_o;

  // lookup request goes out the cycle after acceptance
  assign desc_bus.valid   = held_q && !issued_q;
  assign desc_bus.payload = desc_q;
  assign held_index_o     = addr_index(desc_q.addr);

  ////////////////////////////////////////////////////////////////////////////
  // routing
  ////////////////////////////////////////////////////////////////////////////
  // both results in and the set free downstream
  assign results_ok = look_bus.valid && guard_bus.valid && !set_locked_i;
  // a hit behind outstanding misses of its id goes the miss way for ordering
  assign to_hit     = look_bus.payload.hit && !guard_bus.payload.id_busy;

  assign hit_valid_o  = results_ok && to_hit;
  assign miss_valid_o = results_ok && !to_hit;
  assign handoff      = (hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i);

  // results are consumed together on the handoff
  assign look_bus.ready  = handoff;
  assign guard_bus.ready = handoff;
  assign lock_set_o      = handoff;
  assign miss_up_o       = miss_valid_o && miss_ready_i;

  assign out_desc_o      = desc_q;
  assign out_way_o       = look_bus.payload.way;
  assign out_refill_o    = !look_bus.payload.hit;
  assign out_evict_o     = look_bus.payload.evict;
  assign out_evict_tag_o = look_bus.payload.evict_tag;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q   <= 1'b0;
      issued_q <= 1'b0;
    end else if (accept) begin
      held_q   <= 1'b1;
      issued_q <= 1'b0;
    end else begin
      if (desc_bus.valid && desc_bus.ready) begin
        issued_q <= 1'b1;
      end
      if (handoff) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q <= desc_i;
    end
  end

  // each descriptor leaves on exactly one port
  one_port_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_o && miss_valid_o))
    else $error("route_ctrl: hit and miss valid together");

endmodule

// ==== logic/stage_if.sv ====
`timescale 1ns/1ns

// valid/ready link between stages, payload type set per instance
interface stage_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t payload;

  // producer holds valid and payload stable until valid && ready
  modport producer (
    output valid,
    output payload,
    input  ready
  );

  // consumer only answers with ready
  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// ==== logic/tag_lookup.sv ====
`timescale 1ns/1ns
`include "hit_miss_cfg.svh"

module tag_lookup
  import hit_miss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  stage_if.consumer desc_bus,
  stage_if.producer look_bus
);

  // tag array is plain storage, valid and dirty clear on reset
  tag_t                              tag_q [`HM_SETS][`HM_WAYS];
  logic [`HM_SETS-1:0][`HM_WAYS-1:0] valid_q;
  logic [`HM_SETS-1:0][`HM_WAYS-1:0] dirty_q;
  // round-robin victim pointer per set
  logic [`HM_SETS-1:0]               rr_q;

  lookup_res_t res_q;
  lookup_res_t res_d;
  logic        res_valid_q;

  index_t idx;
  tag_t   tag;
  way_t   set_valid;
  way_t   set_dirty;
  way_t   hit_way;
  way_t   victim;
  tag_t   old_tag;
  logic   hit;
  logic   any_free;
  logic   take;

  assign idx       = addr_index(desc_bus.payload.addr);
  assign tag       = addr_tag(desc_bus.payload.addr);
  assign set_valid = valid_q[idx];
  assign set_dirty = dirty_q[idx];
  // one lookup at a time, accept only with the result slot empty
  assign desc_bus.ready = ~res_valid_q;
  assign take           = desc_bus.valid && desc_bus.ready;

  ////////////////////////////////////////////////////////////////////////////
  // hit detection and victim choice
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `HM_WAYS; w++) begin
      hit_way[w] = set_valid[w] && (tag_q[idx][w] == tag);
    end
  end
  assign hit = |hit_way;

  // lowest invalid way first, else the round-robin way
  always_comb begin
    victim   = '0;
    any_free = 1'b0;
    for (int w = 0; w < `HM_WAYS; w++) begin
      if (!set_valid[w] && !any_free) begin
        victim[w] = 1'b1;
        any_free  = 1'b1;
      end
    end
    if (!any_free) begin
      victim[rr_q[idx]] = 1'b1;
    end
  end

  // tag currently sitting in the victim way
  always_comb begin
    old_tag = '0;
    for (int w = 0; w < `HM_WAYS; w++) begin
      if (victim[w]) begin
        old_tag = tag_q[idx][w];
      end
    end
  end

  always_comb begin
    res_d.hit       = hit;
    res_d.way       = hit ? hit_way : victim;
    res_d.evict     = !hit && |(victim & set_valid & set_dirty);
    res_d.evict_tag = res_d.evict ? old_tag : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tag store update
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
      rr_q    <= '0;
    end else if (take) begin
      if (hit) begin
        // a write hit dirties the line, a read leaves it alone
        dirty_q[idx] <= set_dirty | (hit_way & {`HM_WAYS{desc_bus.payload.write}});
      end else begin
        valid_q[idx] <= set_valid | victim;
        dirty_q[idx] <= (set_dirty & ~victim) | (victim & {`HM_WAYS{desc_bus.payload.write}});
        // pointer only advances when it picked the victim
        if (!any_free) begin
          rr_q[idx] <= ~rr_q[idx];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take && !hit) begin
      for (int w = 0; w < `HM_WAYS; w++) begin
        if (victim[w]) begin
          tag_q[idx][w] <= tag;
        end
      end
    end
  end

  // result slot, emptied when route_ctrl hands the descriptor off
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (take) begin
      res_valid_q <= 1'b1;
    end else if (look_bus.valid && look_bus.ready) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      res_q <= res_d;
    end
  end

  assign look_bus.valid   = res_valid_q;
  assign look_bus.payload = res_q;

  // a held result always names exactly one way
  way_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    look_bus.valid |-> $onehot(look_bus.payload.way))
    else $error("tag_lookup: result way is not one-hot");

endmodule

// ==== vlog.f ====
+incdir+logic
logic/hit_miss_pkg.sv
logic/stage_if.sv
logic/tag_lookup.sv
logic/line_guard.sv
logic/route_ctrl.sv
logic/hit_miss_top.sv
bench/hit_miss_tb.sv
